/* logic/fetch_port_ctrl.sv */
/*
 * Uncached fetch of one port, one line refill per fetch.
 * The requester holds inst_addr_i and inst_valid_i until inst_ready_o,
 * which pulses one cycle after the line arrives.
 */
module fetch_port_ctrl (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  icache_pkg::fetch_addr_t inst_addr_i,
  input  logic                    inst_valid_i,
  output logic                    inst_ready_o,
  output icache_pkg::fetch_data_t inst_data_o,
  output logic                    inst_error_o,
  fetch_port_if.ctrl              port_o
);
  import icache_pkg::*;

  localparam int unsigned AddrW = $bits(fetch_addr_t);
  localparam int unsigned DataW = $bits(fetch_data_t);

  typedef enum logic [1:0] {
    Idle,
    RequestData,
    WaitResponse,
    PresentResponse
  } state_e;

  state_e state_d;
  state_e state_q;

  logic [LINE_ALIGN-1:0] byte_off;
  logic [LINE_ALIGN-1:0] word_sel;
  line_t                 line_shifted;

  // Request the whole line that holds the word
  assign port_o.req_addr  = {inst_addr_i[AddrW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  assign port_o.req_valid = (state_q == RequestData);

  // Word index inside the line, zero when a line is a single word
  assign byte_off     = inst_addr_i[LINE_ALIGN-1:0];
  assign word_sel     = byte_off >> FETCH_ALIGN;
  assign line_shifted = port_o.rsp_line >> (word_sel * DataW);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (inst_valid_i) begin
          state_d = RequestData;
        end
      end
      RequestData: begin
        if (port_o.req_ready) begin
          state_d = WaitResponse;
        end
      end
      WaitResponse: begin
        if (port_o.rsp_valid) begin
          state_d = PresentResponse;
        end
      end
      // Word sits in the output register for exactly this cycle
      PresentResponse: begin
        state_d = Idle;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == WaitResponse && port_o.rsp_valid) begin
      inst_data_o  <= line_shifted[DataW-1:0];
      inst_error_o <= port_o.rsp_error;
    end
  end

  assign inst_ready_o = (state_q == PresentResponse);

  // Address is used live for both the request and the word select
  a_addr_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (state_q != Idle) |-> $stable(inst_addr_i));

endmodule

/* logic/fetch_port_if.sv */
/*
 * Line request and response channel between one port controller and the scheduler.
 * Requests use valid/ready. Responses have no ready and last one cycle.
 */
interface fetch_port_if;
  import icache_pkg::*;

  // Request channel, address is already line aligned
  logic        req_valid;
  fetch_addr_t req_addr;
  logic        req_ready;

  // Response channel, one pulse per accepted request
  logic  rsp_valid;
  line_t rsp_line;
  logic  rsp_error;

  modport ctrl (
    output req_valid,
    output req_addr,
    input  req_ready,
    input  rsp_valid,
    input  rsp_line,
    input  rsp_error
  );

  modport sched (
    input  req_valid,
    input  req_addr,
    output req_ready,
    output rsp_valid,
    output rsp_line,
    output rsp_error
  );

endinterface

/* logic/icache_bypass.sv */
/*
 * Uncached instruction fetch with several ports sharing one line refill port.
 * Every fetch costs one full line refill and nothing is kept between fetches.
 * Refill responses must come back in request order and are always accepted.
 */
`include "icache_params.svh"

module icache_bypass (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,

  input  icache_pkg::fetch_addr_t [`ICACHE_NR_FETCH_PORTS-1:0]   inst_addr_i,
  input  logic                    [`ICACHE_NR_FETCH_PORTS-1:0]   inst_valid_i,
  output logic                    [`ICACHE_NR_FETCH_PORTS-1:0]   inst_ready_o,
  output icache_pkg::fetch_data_t [`ICACHE_NR_FETCH_PORTS-1:0]   inst_data_o,
  output logic                    [`ICACHE_NR_FETCH_PORTS-1:0]   inst_error_o,

  output icache_pkg::fetch_addr_t                                refill_req_addr_o,
  output logic                                                   refill_req_valid_o,
  input  logic                                                   refill_req_ready_i,

  input  icache_pkg::line_t                                      refill_rsp_line_i,
  input  logic                                                   refill_rsp_error_i,
  input  logic                                                   refill_rsp_valid_i
);

  // One request and response channel per fetch port
  fetch_port_if port_if [`ICACHE_NR_FETCH_PORTS] ();

  for (genvar i = 0; i < `ICACHE_NR_FETCH_PORTS; i++) begin : gen_port
    fetch_port_ctrl i_port_ctrl (
      .clk_i,
      .arst_n_i,
      .inst_addr_i  ( inst_addr_i[i]  ),
      .inst_valid_i ( inst_valid_i[i] ),
      .inst_ready_o ( inst_ready_o[i] ),
      .inst_data_o  ( inst_data_o[i]  ),
      .inst_error_o ( inst_error_o[i] ),
      .port_o       ( port_if[i]      )
    );
  end

  // Shared arbiter and response router in front of the refill port
  refill_scheduler i_scheduler (
    .clk_i,
    .arst_n_i,
    .ports_i            ( port_if            ),
    .refill_req_addr_o  ( refill_req_addr_o  ),
    .refill_req_valid_o ( refill_req_valid_o ),
    .refill_req_ready_i ( refill_req_ready_i ),
    .refill_rsp_line_i  ( refill_rsp_line_i  ),
    .refill_rsp_error_i ( refill_rsp_error_i ),
    .refill_rsp_valid_i ( refill_rsp_valid_i )
  );

endmodule

/* logic/icache_params.svh */
/*
 * Build-time sizing of the bypass fetch path.
 * FETCH_DW and LINE_WIDTH must be powers of two with LINE_WIDTH >= FETCH_DW.
 * ORDER_DEPTH bounds the refills in flight and must be at least 2.
 */
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Number of independent fetch ports
`define ICACHE_NR_FETCH_PORTS 2

`define ICACHE_FETCH_AW 32
`define ICACHE_FETCH_DW 32

// Width of one refill line in bits
`define ICACHE_LINE_WIDTH 128

// Outstanding refills tracked by the scheduler
`define ICACHE_ORDER_DEPTH 4

`endif

/* logic/icache_pkg.sv */
/*
 * Shared types of the bypass fetch path.
 * All widths come from icache_params.svh.
 */
`include "icache_params.svh"

package icache_pkg;

  // Byte-offset bits inside one line and inside one fetch word
  localparam int unsigned LINE_ALIGN  = $clog2(`ICACHE_LINE_WIDTH / 8);
  localparam int unsigned FETCH_ALIGN = $clog2(`ICACHE_FETCH_DW / 8);

  // Fetch address, byte granular
  typedef logic [`ICACHE_FETCH_AW-1:0] fetch_addr_t;

  // One instruction word as returned to a fetch port
  typedef logic [`ICACHE_FETCH_DW-1:0] fetch_data_t;

  // One refill line as delivered by the refill port
  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;

  // One-hot port select, bit i stands for fetch port i
  typedef logic [`ICACHE_NR_FETCH_PORTS-1:0] port_sel_t;

endpackage

/* logic/order_fifo.sv */
/*
 * Small FIFO of one-hot port selects, one entry per outstanding refill.
 * DEPTH may be any value of two or more. The user must not push when full
 * or pop when empty. Read data is the head entry, shown combinationally.
 */
module order_fifo #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  push_i,
  input  icache_pkg::port_sel_t data_i,
  output logic                  full_o,
  input  logic                  pop_i,
  output icache_pkg::port_sel_t data_o,
  output logic                  empty_o
);
  import icache_pkg::*;

  localparam int unsigned PtrW = $clog2(DEPTH);
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  port_sel_t       mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  assign full_o  = (count_q == CntW'(DEPTH));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Pointers wrap explicitly so that DEPTH need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    full_o |-> !push_i);
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    empty_o |-> !pop_i);

endmodule

/* logic/refill_scheduler.sv */
/*
 * Round-robin arbitration of the port line requests onto one refill port.
 * Refill responses must return in request order and are always accepted.
 * At most ICACHE_ORDER_DEPTH refills are in flight.
 */
`include "icache_params.svh"

module refill_scheduler (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  fetch_port_if.sched             ports_i [`ICACHE_NR_FETCH_PORTS],
  output icache_pkg::fetch_addr_t refill_req_addr_o,
  output logic                    refill_req_valid_o,
  input  logic                    refill_req_ready_i,
  input  icache_pkg::line_t       refill_rsp_line_i,
  input  logic                    refill_rsp_error_i,
  input  logic                    refill_rsp_valid_i
);
  import icache_pkg::*;

  localparam int unsigned NrPorts = `ICACHE_NR_FETCH_PORTS;
  localparam int unsigned IdxW    = (NrPorts > 1) ? $clog2(NrPorts) : 1;

  fetch_addr_t [NrPorts-1:0] req_addr;
  port_sel_t                 req_valid;
  port_sel_t                 gnt_rr;
  port_sel_t                 gnt;
  port_sel_t                 gnt_q;
  port_sel_t                 head_sel;
  logic                      lock_q;
  logic [IdxW-1:0]           rr_q;
  logic [IdxW-1:0]           rr_d;
  logic [IdxW-1:0]           gnt_idx;
  logic                      req_ok;
  logic                      req_xfer;
  logic                      fifo_full;
  logic                      fifo_empty;

  // No new refill may start while every order slot is taken
  assign req_ok = ~fifo_full;

  for (genvar i = 0; i < NrPorts; i++) begin : gen_port
    assign req_valid[i]        = ports_i[i].req_valid & req_ok;
    assign req_addr[i]         = ports_i[i].req_addr;
    assign ports_i[i].req_ready = gnt[i] & refill_req_ready_i & req_ok;
    // Responses are broadcast and only the head owner sees a valid
    assign ports_i[i].rsp_valid = refill_rsp_valid_i & head_sel[i];
    assign ports_i[i].rsp_line  = refill_rsp_line_i;
    assign ports_i[i].rsp_error = refill_rsp_error_i;
  end

  // First requester at or after the priority pointer wins
  always_comb begin
    int unsigned idx;
    logic found;
    found  = 1'b0;
    gnt_rr = '0;
    for (int unsigned k = 0; k < NrPorts; k++) begin
      idx = (rr_q + k) % NrPorts;
      if (!found && req_valid[idx]) begin
        gnt_rr[idx] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  // A stalled refill request keeps its grant
  assign gnt = lock_q ? gnt_q : gnt_rr;

  always_comb begin
    gnt_idx           = '0;
    refill_req_addr_o = '0;
    for (int unsigned i = 0; i < NrPorts; i++) begin
      if (gnt[i]) begin
        gnt_idx           = IdxW'(i);
        refill_req_addr_o = refill_req_addr_o | req_addr[i];
      end
    end
  end

  assign rr_d = (gnt_idx == IdxW'(NrPorts - 1)) ? '0 : gnt_idx + 1'b1;

  assign refill_req_valid_o = (|gnt) & req_ok;
  assign req_xfer           = refill_req_valid_o & refill_req_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
      gnt_q  <= '0;
      rr_q   <= '0;
    end else begin
      lock_q <= refill_req_valid_o & ~refill_req_ready_i;
      gnt_q  <= gnt;
      if (req_xfer) begin
        rr_q <= rr_d;
      end
    end
  end

  order_fifo #(
    .DEPTH ( `ICACHE_ORDER_DEPTH )
  ) i_order_fifo (
    .clk_i,
    .arst_n_i,
    .push_i  ( req_xfer           ),
    .data_i  ( gnt                ),
    .full_o  ( fifo_full          ),
    .pop_i   ( refill_rsp_valid_i ),
    .data_o  ( head_sel           ),
    .empty_o ( fifo_empty         )
  );

  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt));
  // Every response must belong to a refill that was issued earlier
  a_rsp_owned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    refill_rsp_valid_i |-> !fifo_empty);

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the bypass fetch testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_icache_bypass -Mdir obj_dir -o sim_icache_bypass > build.log 2>&1 &&
./obj_dir/sim_icache_bypass > sim.log 2>&1 ||
echo "Build or simulation returned an error, see build.log and sim.log"
cat sim.log 2> /dev/null
grep -qx "PASS: all tests" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* src.f */
+incdir+logic
logic/icache_pkg.sv
logic/fetch_port_if.sv
logic/order_fifo.sv
logic/fetch_port_ctrl.sv
logic/refill_scheduler.sv
logic/icache_bypass.sv
testbench/refill_mem_model.sv
testbench/tb_icache_bypass.sv

/* testbench/refill_mem_model.sv */
/*
 * In-order line memory behind the refill port.
 * Word k of the line at A reads (A + 4k) xor 32'hC0DE0000, error when A[12] is set.
 * Stalls and response delays follow rand_i, which must change every cycle.
 */
module refill_mem_model (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [15:0]             rand_i,
  input  icache_pkg::fetch_addr_t req_addr_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output icache_pkg::line_t       rsp_line_o,
  output logic                    rsp_error_o,
  output logic                    rsp_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int unsigned NrWords = $bits(line_t) / 32;

  // Accepted line addresses waiting for their response
  fetch_addr_t pending_q [$];
  int unsigned delay_q;

  function automatic line_t line_content(input fetch_addr_t addr);
    line_t line;
    line = '0;
    for (int unsigned k = 0; k < NrWords; k++) begin
      line[k*32 +: 32] = (addr + 32'(4 * k)) ^ 32'hC0DE0000;
    end
    return line;
  endfunction

  initial begin
    req_ready_o = 1'b0;
    rsp_valid_o = 1'b0;
    rsp_error_o = 1'b0;
    rsp_line_o  = '0;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    fetch_addr_t head;
    if (!arst_n_i) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_error_o <= 1'b0;
      rsp_line_o  <= '0;
      pending_q.delete();
      delay_q = 0;
    end else begin
      // About one cycle in four stalls the request side
      req_ready_o <= (rand_i[1:0] != 2'b00);
      rsp_valid_o <= 1'b0;
      if (req_valid_i && req_ready_o) begin
        pending_q.push_back(req_addr_i);
      end
      if (pending_q.size() != 0) begin
        if (delay_q == 0) begin
          head = pending_q.pop_front();
          rsp_valid_o <= 1'b1;
          rsp_line_o  <= line_content(head);
          rsp_error_o <= head[12];
          // Gap before the next line may be answered
          delay_q = 32'(rand_i[6:4]);
        end else begin
          delay_q = delay_q - 1;
        end
      end
    end
  end

endmodule

/* testbench/tb_icache_bypass.sv */
/*
 * Random fetches on every port against an in-order refill memory.
 * Port p puts p into address bits 15:14, so at most four ports are supported.
 * Concurrent assertions check data, errors, refill protocol and round-robin order.
 */
`include "icache_params.svh"

module tb_icache_bypass;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int unsigned NrPorts    = `ICACHE_NR_FETCH_PORTS;
  localparam int unsigned NrFetches  = 40;
  localparam int unsigned CycleLimit = NrFetches * NrPorts * 40;
  localparam logic [31:0] Seed       = 32'd79545;

  logic                      clk_i        = 1'b0;
  logic                      arst_n_i     = 1'b0;
  fetch_addr_t [NrPorts-1:0] inst_addr_i  = '0;
  logic [NrPorts-1:0]        inst_valid_i = '0;
  logic [NrPorts-1:0]        inst_ready_o;
  fetch_data_t [NrPorts-1:0] inst_data_o;
  logic [NrPorts-1:0]        inst_error_o;
  fetch_addr_t               refill_req_addr_o;
  logic                      refill_req_valid_o;
  logic                      refill_req_ready_i;
  line_t                     refill_rsp_line_i;
  logic                      refill_rsp_error_i;
  logic                      refill_rsp_valid_i;
  logic [15:0]               mem_rand     = '0;
  logic [31:0]               rng_state    = Seed;

  int unsigned issued [NrPorts];
  int unsigned completed [NrPorts];
  int unsigned gap [NrPorts];

  // Scoreboard of refill traffic and of ports waiting for a grant
  int unsigned        outstanding;
  int unsigned        passes [NrPorts];
  logic [NrPorts-1:0] armed;
  logic [NrPorts-1:0] granted;
  logic               req_xfer;
  logic [1:0]         xfer_port;

  function automatic logic [15:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state[31:16];
  endfunction

  function automatic fetch_addr_t random_fetch_addr(input int unsigned port);
    logic [15:0] hi;
    logic [15:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi, 2'(port), lo[11:0], 2'b00};
  endfunction

  // Word at addr under the memory rule, from its line address and word index
  function automatic fetch_data_t expected_word(input fetch_addr_t addr);
    fetch_addr_t line_addr;
    int unsigned k;
    line_addr = addr & ~fetch_addr_t'((1 << LINE_ALIGN) - 1);
    k = (addr - line_addr) / 4;
    return (line_addr + 32'(4 * k)) ^ 32'hC0DE0000;
  endfunction

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int unsigned p = 0; p < NrPorts; p++) begin
      if (completed[p] != NrFetches) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    report_error($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  icache_bypass i_dut (
    .clk_i,
    .arst_n_i,
    .inst_addr_i,
    .inst_valid_i,
    .inst_ready_o,
    .inst_data_o,
    .inst_error_o,
    .refill_req_addr_o,
    .refill_req_valid_o,
    .refill_req_ready_i,
    .refill_rsp_line_i,
    .refill_rsp_error_i,
    .refill_rsp_valid_i
  );

  refill_mem_model i_mem (
    .clk_i,
    .arst_n_i,
    .rand_i      ( mem_rand           ),
    .req_addr_i  ( refill_req_addr_o  ),
    .req_valid_i ( refill_req_valid_o ),
    .req_ready_o ( refill_req_ready_i ),
    .rsp_line_o  ( refill_rsp_line_i  ),
    .rsp_error_o ( refill_rsp_error_i ),
    .rsp_valid_o ( refill_rsp_valid_i )
  );

  always #4 clk_i = ~clk_i;

  // Each port fetches, waits for inst_ready_o, then idles for a random gap
  always @(posedge clk_i) begin
    mem_rand <= next_rand();
    if (!arst_n_i) begin
      for (int unsigned p = 0; p < NrPorts; p++) begin
        issued[p]    <= 0;
        completed[p] <= 0;
        gap[p]       <= 0;
      end
    end else begin
      for (int unsigned p = 0; p < NrPorts; p++) begin
        if (inst_valid_i[p]) begin
          if (inst_ready_o[p]) begin
            inst_valid_i[p] <= 1'b0;
            completed[p]    <= completed[p] + 1;
            gap[p]          <= 32'(next_rand() % 4);
          end
        end else if (issued[p] < NrFetches) begin
          if (gap[p] == 0) begin
            inst_valid_i[p] <= 1'b1;
            inst_addr_i[p]  <= random_fetch_addr(p);
            issued[p]       <= issued[p] + 1;
          end else begin
            gap[p] <= gap[p] - 1;
          end
        end
      end
    end
  end

  assign req_xfer  = refill_req_valid_o & refill_req_ready_i;
  assign xfer_port = refill_req_addr_o[15:14];

  // A port requests a line from the cycle after its fetch starts until its grant
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding <= 0;
      armed       <= '0;
      granted     <= '0;
      for (int unsigned p = 0; p < NrPorts; p++) begin
        passes[p] <= 0;
      end
    end else begin
      outstanding <= outstanding + (req_xfer ? 1 : 0) - (refill_rsp_valid_i ? 1 : 0);
      for (int unsigned p = 0; p < NrPorts; p++) begin
        if (inst_ready_o[p]) begin
          armed[p]   <= 1'b0;
          granted[p] <= 1'b0;
        end else if (inst_valid_i[p]) begin
          armed[p] <= 1'b1;
        end
        // Count the refills that went to other ports while this one waited
        if (req_xfer) begin
          if (xfer_port == 2'(p)) begin
            granted[p] <= 1'b1;
            passes[p]  <= 0;
          end else if (armed[p] && !granted[p]) begin
            passes[p] <= passes[p] + 1;
          end
        end
      end
    end
  end

  for (genvar p = 0; p < NrPorts; p++) begin : gen_port_check
    a_data : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |-> inst_data_o[p] == expected_word(inst_addr_i[p]))
      else report_mismatch($sformatf("inst_data_o[%0d]", p), $sampled(inst_data_o[p]),
                           expected_word($sampled(inst_addr_i[p])));
    a_error : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |-> inst_error_o[p] == inst_addr_i[p][12])
      else report_mismatch($sformatf("inst_error_o[%0d]", p), 32'($sampled(inst_error_o[p])),
                           32'($sampled(inst_addr_i[p][12])));
    a_single_pulse : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |=> !inst_ready_o[p])
      else report_error($sformatf("inst_ready_o[%0d] stayed high for two cycles", p));
    a_ready_in_fetch : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      inst_ready_o[p] |-> inst_valid_i[p])
      else report_error($sformatf("inst_ready_o[%0d] pulsed with no fetch pending", p));
    // Round robin serves each other port at most once before a waiting port
    a_round_robin : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      passes[p] < NrPorts)
      else report_error($sformatf("Port %0d was passed over %0d times by the refill arbiter",
                                  p, $sampled(passes[p])));
  end

  a_line_aligned : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_xfer |-> refill_req_addr_o[LINE_ALIGN-1:0] == '0)
    else report_mismatch("refill_req_addr_o", $sampled(refill_req_addr_o),
                         $sampled(refill_req_addr_o) & ~32'((1 << LINE_ALIGN) - 1));
  a_req_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    refill_req_valid_o && !refill_req_ready_i |=>
      refill_req_valid_o && $stable(refill_req_addr_o))
    else report_error("Stalled refill request was dropped or changed its address");
  a_outstanding : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    outstanding <= `ICACHE_ORDER_DEPTH)
    else report_error("More refills in flight than the order FIFO can track");
  a_reset_quiet : assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> inst_ready_o == '0 && !refill_req_valid_o)
    else report_error("Fetch or refill outputs active right after reset");

  initial begin
    int unsigned cycles;
    cycles = 0;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    while (!all_done() && cycles < CycleLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    if (all_done()) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      report_error($sformatf("Timeout after %0d cycles with fetches still open", cycles));
    end
  end

endmodule
